/* rtl/frame_mem_pkg.sv */
`default_nettype none

package frame_mem_pkg;

	// image geometry, two pixels per memory word
	localparam int IMG_WIDTH  = 640;
	localparam int IMG_HEIGHT = 480;
	localparam int ROW_WORDS  = IMG_WIDTH / 2;
	localparam int SLOT_WORDS = ROW_WORDS * IMG_HEIGHT;
	localparam int NUM_SLOTS  = 3;

	// coordinate and memory widths
	localparam int X_W    = $clog2(IMG_WIDTH);
	localparam int Y_W    = $clog2(IMG_HEIGHT);
	localparam int SLOT_W = $clog2(NUM_SLOTS);
	localparam int ADDR_W = $clog2(NUM_SLOTS * SLOT_WORDS);
	localparam int WORD_W = 36;

	// one-hot client codes, also used as bank command tags
	localparam int CLIENT_W = 3;
	localparam logic [CLIENT_W-1:0] CLIENT_NONE = 3'b000;
	localparam logic [CLIENT_W-1:0] CLIENT_NTSC = 3'b100;
	localparam logic [CLIENT_W-1:0] CLIENT_VGA  = 3'b010;
	localparam logic [CLIENT_W-1:0] CLIENT_LPF  = 3'b001;

endpackage

`default_nettype wire

/* rtl/buffer_rotation.sv */
`default_nettype none

module buffer_rotation (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         frame_flag,
	output logic                         capt_bank,
	output logic                         proc_bank,
	output logic                         nexd_bank,
	output logic                         disp_bank,
	output logic [frame_mem_pkg::SLOT_W-1:0] capt_slot,
	output logic [frame_mem_pkg::SLOT_W-1:0] proc_slot,
	output logic [frame_mem_pkg::SLOT_W-1:0] nexd_slot,
	output logic [frame_mem_pkg::SLOT_W-1:0] disp_slot
);

	import frame_mem_pkg::*;

	// all four roles move together on the frame flag
	always_ff @(posedge clk) begin
		if (reset) begin
			capt_bank <= 1'b0;
			capt_slot <= SLOT_W'(0);
			proc_bank <= 1'b0;
			proc_slot <= SLOT_W'(1);
			nexd_bank <= 1'b1;
			nexd_slot <= SLOT_W'(0);
			disp_bank <= 1'b1;
			disp_slot <= SLOT_W'(1);
		end else if (frame_flag) begin
			// finished capture waits as next-display
			capt_bank <= proc_bank;
			capt_slot <= proc_slot;
			proc_bank <= disp_bank;
			proc_slot <= disp_slot;
			nexd_bank <= capt_bank;
			nexd_slot <= capt_slot;
			disp_bank <= nexd_bank;
			disp_slot <= nexd_slot;
		end
	end

	// the capture writer must never overwrite the frame on screen
	a_capt_not_disp: assert property (
		@(posedge clk) disable iff (reset)
		!(capt_bank == disp_bank && capt_slot == disp_slot)
	) else $error("capture and display roles share a buffer");

endmodule

`default_nettype wire

/* rtl/pixel_address.sv */
`default_nettype none

module pixel_address (
	input  logic [frame_mem_pkg::X_W-1:0]    x,
	input  logic [frame_mem_pkg::Y_W-1:0]    y,
	input  logic [frame_mem_pkg::SLOT_W-1:0] slot,
	output logic [frame_mem_pkg::ADDR_W-1:0] addr
);

	import frame_mem_pkg::*;

	logic [ADDR_W-1:0] row_off;
	logic [ADDR_W-1:0] col_off;
	logic [ADDR_W-1:0] slot_off;

	// line offset, constant multiply
	assign row_off = ADDR_W'(y) * ADDR_W'(ROW_WORDS);

	// two pixels share a word, so drop the low x bit
	assign col_off = ADDR_W'(x[X_W-1:1]);

	// base of the image slot within the bank
	assign slot_off = ADDR_W'(slot) * ADDR_W'(SLOT_WORDS);

	assign addr = row_off + col_off + slot_off;

endmodule

`default_nettype wire

/* rtl/bank_arbiter.sv */
`default_nettype none

module bank_arbiter #(
	parameter int BANK = 0
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             ntsc_flag,
	input  logic                             vga_flag,
	input  logic                             lpf_flag,
	input  logic                             lpf_wr,
	input  logic [frame_mem_pkg::ADDR_W-1:0]   ntsc_addr,
	input  logic [frame_mem_pkg::ADDR_W-1:0]   vga_addr,
	input  logic [frame_mem_pkg::ADDR_W-1:0]   lpf_addr,
	input  logic [frame_mem_pkg::WORD_W-1:0]   ntsc_pixel,
	input  logic [frame_mem_pkg::WORD_W-1:0]   lpf_pixel_write,
	input  logic                             capt_bank,
	input  logic                             disp_bank,
	input  logic                             proc_bank,
	output logic [frame_mem_pkg::ADDR_W-1:0]   mem_addr,
	output logic [frame_mem_pkg::WORD_W-1:0]   mem_write,
	output logic                             mem_wr,
	output logic [frame_mem_pkg::CLIENT_W-1:0] grant
);

	import frame_mem_pkg::*;

	localparam logic BANK_SEL = 1'(BANK);

	logic sel_ntsc;
	logic sel_vga;
	logic sel_lpf;

	// fixed priority: capture, then display, then filter
	always_comb begin
		sel_ntsc = ntsc_flag && (capt_bank == BANK_SEL);
		sel_vga  = vga_flag && (disp_bank == BANK_SEL) && !sel_ntsc;
		sel_lpf  = lpf_flag && (proc_bank == BANK_SEL) && !sel_ntsc && !sel_vga;
	end

	// registered command and its client tag
	always_ff @(posedge clk) begin
		if (reset) begin
			mem_addr <= '0;
			mem_wr   <= 1'b0;
			grant    <= CLIENT_NONE;
		end else if (sel_ntsc) begin
			mem_addr <= ntsc_addr;
			mem_wr   <= 1'b1;
			grant    <= CLIENT_NTSC;
		end else if (sel_vga) begin
			mem_addr <= vga_addr;
			mem_wr   <= 1'b0;
			grant    <= CLIENT_VGA;
		end else if (sel_lpf) begin
			mem_addr <= lpf_addr;
			mem_wr   <= lpf_wr;
			grant    <= CLIENT_LPF;
		end else begin
			mem_addr <= '0;
			mem_wr   <= 1'b0;
			grant    <= CLIENT_NONE;
		end
	end

	// write data, left alone on a display read
	always_ff @(posedge clk) begin
		if (sel_ntsc)
			mem_write <= ntsc_pixel;
		else if (sel_lpf)
			mem_write <= lpf_pixel_write;
		else if (!sel_vga)
			mem_write <= '0;
	end

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(grant)
	) else $error("bank %0d granted more than one client", BANK);

	// the display client only ever reads
	a_vga_read_only: assert property (
		@(posedge clk) disable iff (reset)
		mem_wr |-> grant != CLIENT_VGA
	) else $error("bank %0d wrote on a display grant", BANK);

endmodule

`default_nettype wire

/* rtl/client_return.sv */
`default_nettype none

module client_return (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [frame_mem_pkg::CLIENT_W-1:0] grant0,
	input  logic [frame_mem_pkg::CLIENT_W-1:0] grant1,
	input  logic                             write0,
	input  logic                             write1,
	input  logic [frame_mem_pkg::WORD_W-1:0]   mem0_read,
	input  logic [frame_mem_pkg::WORD_W-1:0]   mem1_read,
	output logic                             done_ntsc,
	output logic                             done_vga,
	output logic                             done_lpf,
	output logic [frame_mem_pkg::WORD_W-1:0]   vga_pixel,
	output logic [frame_mem_pkg::WORD_W-1:0]   lpf_pixel_read
);

	import frame_mem_pkg::*;

	// read tags, one slot per bank and stage
	logic [CLIENT_W-1:0] rd_code0;
	logic [CLIENT_W-1:0] rd_code1;
	logic [CLIENT_W-1:0] rd0_q1;
	logic [CLIENT_W-1:0] rd0_q2;
	logic [CLIENT_W-1:0] rd1_q1;
	logic [CLIENT_W-1:0] rd1_q2;

	// a granted command completes in the cycle it is on the bank
	assign done_ntsc = (grant0 == CLIENT_NTSC) || (grant1 == CLIENT_NTSC);
	assign done_vga  = (grant0 == CLIENT_VGA) || (grant1 == CLIENT_VGA);
	assign done_lpf  = (grant0 == CLIENT_LPF) || (grant1 == CLIENT_LPF);

	// writes return nothing
	assign rd_code0 = write0 ? CLIENT_NONE : grant0;
	assign rd_code1 = write1 ? CLIENT_NONE : grant1;

	// two stages match the sram read latency
	always_ff @(posedge clk) begin
		if (reset) begin
			rd0_q1 <= CLIENT_NONE;
			rd0_q2 <= CLIENT_NONE;
			rd1_q1 <= CLIENT_NONE;
			rd1_q2 <= CLIENT_NONE;
		end else begin
			rd0_q1 <= rd_code0;
			rd0_q2 <= rd0_q1;
			rd1_q1 <= rd_code1;
			rd1_q2 <= rd1_q1;
		end
	end

	// steer returning data to its client, otherwise hold
	always_ff @(posedge clk) begin
		if (reset) begin
			vga_pixel      <= '0;
			lpf_pixel_read <= '0;
		end else begin
			if (rd0_q2 == CLIENT_VGA)
				vga_pixel <= mem0_read;
			else if (rd1_q2 == CLIENT_VGA)
				vga_pixel <= mem1_read;

			if (rd0_q2 == CLIENT_LPF)
				lpf_pixel_read <= mem0_read;
			else if (rd1_q2 == CLIENT_LPF)
				lpf_pixel_read <= mem1_read;
		end
	end

	// a client's buffer lives in one bank, so returns never collide
	a_no_double_return: assert property (
		@(posedge clk) disable iff (reset)
		(rd0_q2 & rd1_q2) == CLIENT_NONE
	) else $error("both banks return to the same client");

endmodule

`default_nettype wire

/* rtl/frame_mem_top.sv */
`default_nettype none

module frame_mem_top (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           frame_flag,
	// capture writer
	input  logic                           ntsc_flag,
	input  logic [frame_mem_pkg::X_W-1:0]    ntsc_x,
	input  logic [frame_mem_pkg::Y_W-1:0]    ntsc_y,
	input  logic [frame_mem_pkg::WORD_W-1:0] ntsc_pixel,
	// display reader
	input  logic                           vga_flag,
	input  logic [frame_mem_pkg::X_W-1:0]    hcount,
	input  logic [frame_mem_pkg::Y_W-1:0]    vcount,
	// filter client
	input  logic                           lpf_flag,
	input  logic                           lpf_wr,
	input  logic [frame_mem_pkg::X_W-1:0]    lpf_x,
	input  logic [frame_mem_pkg::Y_W-1:0]    lpf_y,
	input  logic [frame_mem_pkg::WORD_W-1:0] lpf_pixel_write,
	// sram banks
	input  logic [frame_mem_pkg::WORD_W-1:0] mem0_read,
	output logic [frame_mem_pkg::ADDR_W-1:0] mem0_addr,
	output logic [frame_mem_pkg::WORD_W-1:0] mem0_write,
	output logic                           mem0_wr,
	input  logic [frame_mem_pkg::WORD_W-1:0] mem1_read,
	output logic [frame_mem_pkg::ADDR_W-1:0] mem1_addr,
	output logic [frame_mem_pkg::WORD_W-1:0] mem1_write,
	output logic                           mem1_wr,
	// client results
	output logic                           done_ntsc,
	output logic                           done_vga,
	output logic                           done_lpf,
	output logic [frame_mem_pkg::WORD_W-1:0] vga_pixel,
	output logic [frame_mem_pkg::WORD_W-1:0] lpf_pixel_read
);

	import frame_mem_pkg::*;

	logic              capt_bank;
	logic              proc_bank;
	logic              disp_bank;
	logic [SLOT_W-1:0] capt_slot;
	logic [SLOT_W-1:0] proc_slot;
	logic [SLOT_W-1:0] disp_slot;

	logic [ADDR_W-1:0] ntsc_addr;
	logic [ADDR_W-1:0] vga_addr;
	logic [ADDR_W-1:0] lpf_addr;

	logic [CLIENT_W-1:0] grant0;
	logic [CLIENT_W-1:0] grant1;

	// next-display is only an internal stop in the rotation
	buffer_rotation rotation_i (
		.clk       (clk),
		.reset     (reset),
		.frame_flag(frame_flag),
		.capt_bank (capt_bank),
		.proc_bank (proc_bank),
		.nexd_bank (),
		.disp_bank (disp_bank),
		.capt_slot (capt_slot),
		.proc_slot (proc_slot),
		.nexd_slot (),
		.disp_slot (disp_slot)
	);

	pixel_address ntsc_addr_i (.x(ntsc_x), .y(ntsc_y), .slot(capt_slot), .addr(ntsc_addr));
	pixel_address vga_addr_i  (.x(hcount), .y(vcount), .slot(disp_slot), .addr(vga_addr));
	pixel_address lpf_addr_i  (.x(lpf_x), .y(lpf_y), .slot(proc_slot), .addr(lpf_addr));

	bank_arbiter #(.BANK(0)) arb0_i (
		.clk(clk), .reset(reset),
		.ntsc_flag(ntsc_flag), .vga_flag(vga_flag), .lpf_flag(lpf_flag), .lpf_wr(lpf_wr),
		.ntsc_addr(ntsc_addr), .vga_addr(vga_addr), .lpf_addr(lpf_addr),
		.ntsc_pixel(ntsc_pixel), .lpf_pixel_write(lpf_pixel_write),
		.capt_bank(capt_bank), .disp_bank(disp_bank), .proc_bank(proc_bank),
		.mem_addr(mem0_addr), .mem_write(mem0_write), .mem_wr(mem0_wr), .grant(grant0)
	);

	bank_arbiter #(.BANK(1)) arb1_i (
		.clk(clk), .reset(reset),
		.ntsc_flag(ntsc_flag), .vga_flag(vga_flag), .lpf_flag(lpf_flag), .lpf_wr(lpf_wr),
		.ntsc_addr(ntsc_addr), .vga_addr(vga_addr), .lpf_addr(lpf_addr),
		.ntsc_pixel(ntsc_pixel), .lpf_pixel_write(lpf_pixel_write),
		.capt_bank(capt_bank), .disp_bank(disp_bank), .proc_bank(proc_bank),
		.mem_addr(mem1_addr), .mem_write(mem1_write), .mem_wr(mem1_wr), .grant(grant1)
	);

	client_return return_i (
		.clk           (clk),
		.reset         (reset),
		.grant0        (grant0),
		.grant1        (grant1),
		.write0        (mem0_wr),
		.write1        (mem1_wr),
		.mem0_read     (mem0_read),
		.mem1_read     (mem1_read),
		.done_ntsc     (done_ntsc),
		.done_vga      (done_vga),
		.done_lpf      (done_lpf),
		.vga_pixel     (vga_pixel),
		.lpf_pixel_read(lpf_pixel_read)
	);

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
`default_nettype none

module clock_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset drops just after a rising edge, like all other stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/sram_model.sv */
`default_nettype none

module sram_model #(
	parameter int BANK = 0
) (
	input  logic                             clk,
	input  logic [frame_mem_pkg::ADDR_W-1:0] addr,
	input  logic [frame_mem_pkg::WORD_W-1:0] write,
	input  logic                             wr,
	output logic [frame_mem_pkg::WORD_W-1:0] read
);

	import frame_mem_pkg::*;

	logic [WORD_W-1:0] mem [int];
	logic [WORD_W-1:0] stage;

	// unwritten words carry a pattern of bank and full address
	function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return {4'(BANK + 1), 13'h1a5, a} ^ 36'h0f0f0f0f0;
	endfunction

	function automatic logic [WORD_W-1:0] lookup(input logic [ADDR_W-1:0] a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		return fill_word(a);
	endfunction

	initial begin
		stage = '0;
		read  = '0;
	end

	// read data shows up two cycles after its address cycle
	always @(posedge clk) begin
		read  <= stage;
		stage <= lookup(addr);
		if (wr)
			mem[int'(addr)] = write;
	end

endmodule

`default_nettype wire

/* testbench/tb_frame_mem.sv */
`default_nettype none

module tb_frame_mem;

	import frame_mem_pkg::*;

	localparam int MAX_ROWS = 64;

	logic clk, reset, frame_flag;
	logic ntsc_flag, vga_flag, lpf_flag, lpf_wr;
	logic [X_W-1:0] ntsc_x, hcount, lpf_x;
	logic [Y_W-1:0] ntsc_y, vcount, lpf_y;
	logic [WORD_W-1:0] ntsc_pixel, lpf_pixel_write, vga_pixel, lpf_pixel_read;
	logic [WORD_W-1:0] mem0_read, mem0_write, mem1_read, mem1_write;
	logic [ADDR_W-1:0] mem0_addr, mem1_addr;
	logic mem0_wr, mem1_wr, done_ntsc, done_vga, done_lpf;

	// op, x, y, data, expected
	logic [99:0] rows [0:MAX_ROWS-1];
	logic [WORD_W-1:0] shadow [int];
	int role_bank [4];
	int role_slot [4];
	int num_rows = 0;
	int errors = 0;
	int checks = 0;
	logic [31:0] lcg_state = 32'h7995d53f;
	logic [WORD_W-1:0] last_vga = '0;
	logic [WORD_W-1:0] last_lpf = '0;

	clock_gen #(.PERIOD(10), .RESET_CYCLES(3)) clock_i (.clk(clk), .reset(reset));

	sram_model #(.BANK(0)) bank0_i (.clk(clk), .addr(mem0_addr), .write(mem0_write),
		.wr(mem0_wr), .read(mem0_read));
	sram_model #(.BANK(1)) bank1_i (.clk(clk), .addr(mem1_addr), .write(mem1_write),
		.wr(mem1_wr), .read(mem1_read));

	frame_mem_top dut_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [ADDR_W-1:0] word_addr(input int x, input int y, input int slot);
		return ADDR_W'(y * ROW_WORDS + x / 2 + slot * SLOT_WORDS);
	endfunction

	function automatic logic [WORD_W-1:0] expect_word(input int bank, input logic [ADDR_W-1:0] a);
		int key;
		key = bank * (1 << ADDR_W) + int'(a);
		if (shadow.exists(key))
			return shadow[key];
		return {4'(bank + 1), 13'h1a5, a} ^ 36'h0f0f0f0f0;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic mismatch(input string msg);
		errors++;
		$display("mismatch at time %0t: %s", $time, msg);
	endtask

	task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
		input string what);
		checks++;
		if (got !== exp)
			mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_done(input logic n, input logic v, input logic l, input string what);
		checks++;
		if ({done_ntsc, done_vga, done_lpf} !== {n, v, l})
			mismatch($sformatf("%s done %b%b%b expected %b%b%b", what,
				done_ntsc, done_vga, done_lpf, n, v, l));
	endtask

	// bank command in the cycle after the request edge
	task automatic check_cmd(input int bank, input logic [ADDR_W-1:0] a, input logic w,
		input logic [WORD_W-1:0] d, input string what);
		logic [ADDR_W-1:0] got_a;
		logic [WORD_W-1:0] got_d;
		logic got_w;
		got_a = (bank == 0) ? mem0_addr : mem1_addr;
		got_d = (bank == 0) ? mem0_write : mem1_write;
		got_w = (bank == 0) ? mem0_wr : mem1_wr;
		checks++;
		if (got_a !== a || got_w !== w)
			mismatch($sformatf("%s bank %0d addr %h wr %b expected addr %h wr %b",
				what, bank, got_a, got_w, a, w));
		if (w && got_d !== d)
			mismatch($sformatf("%s bank %0d data %h expected %h", what, bank, got_d, d));
		if (w)
			shadow[bank * (1 << ADDR_W) + int'(a)] = d;
	endtask

	// hold the request until the chosen done pulse
	// client 0 capture, 1 display, 2 filter
	task automatic wait_for_done(input int which);
		int n;
		logic seen;
		seen = 1'b0;
		for (n = 0; n < 10 && !seen; n++) begin
			next_cycle();
			seen = (which == 0) ? done_ntsc : (which == 1) ? done_vga : done_lpf;
		end
		if (!seen) begin
			errors++;
			$display("no done pulse for client %0d within 10 cycles at time %0t", which, $time);
		end
	endtask

	task automatic capture_write(input int x, input int y, input logic [WORD_W-1:0] d);
		ntsc_flag = 1'b1;
		ntsc_x = X_W'(x);
		ntsc_y = Y_W'(y);
		ntsc_pixel = d;
		wait_for_done(0);
		ntsc_flag = 1'b0;
		check_done(1'b1, 1'b0, 1'b0, "capture write");
		check_cmd(role_bank[0], word_addr(x, y, role_slot[0]), 1'b1, d, "capture write");
	endtask

	task automatic filter_write(input int x, input int y);
		lcg_state = lcg_next(lcg_state);
		lpf_flag = 1'b1;
		lpf_wr = 1'b1;
		lpf_x = X_W'(x);
		lpf_y = Y_W'(y);
		lpf_pixel_write = {lcg_state[3:0], lcg_state};
		wait_for_done(2);
		lpf_flag = 1'b0;
		check_done(1'b0, 1'b0, 1'b1, "filter write");
		check_cmd(role_bank[1], word_addr(x, y, role_slot[1]), 1'b1, lpf_pixel_write,
			"filter write");
	endtask

	task automatic start_filter_read(input int x, input int y);
		lpf_flag = 1'b1;
		lpf_wr = 1'b0;
		lpf_x = X_W'(x);
		lpf_y = Y_W'(y);
	endtask

	task automatic start_display_read(input int x, input int y);
		vga_flag = 1'b1;
		hcount = X_W'(x);
		vcount = Y_W'(y);
	endtask

	task automatic filter_read(input int x, input int y);
		logic [ADDR_W-1:0] a;
		a = word_addr(x, y, role_slot[1]);
		start_filter_read(x, y);
		wait_for_done(2);
		lpf_flag = 1'b0;
		check_cmd(role_bank[1], a, 1'b0, '0, "filter read");
		repeat (3) next_cycle();
		last_lpf = expect_word(role_bank[1], a);
		check_word(lpf_pixel_read, last_lpf, "filter read data");
	endtask

	task automatic display_read(input int x, input int y, input logic [WORD_W-1:0] exp);
		logic [ADDR_W-1:0] a;
		a = word_addr(x, y, role_slot[3]);
		start_display_read(x, y);
		wait_for_done(1);
		vga_flag = 1'b0;
		check_cmd(role_bank[3], a, 1'b0, '0, "display read");
		repeat (3) next_cycle();
		last_vga = expect_word(role_bank[3], a);
		check_word(vga_pixel, last_vga, "display read data");
		if (exp != '0)
			check_word(vga_pixel, exp, "display read against pattern");
	endtask

	// capture and filter collide on one bank and capture wins
	task automatic capture_filter_clash(input int x, input int y, input logic [WORD_W-1:0] d);
		lcg_state = lcg_next(lcg_state);
		ntsc_flag = 1'b1;
		ntsc_x = X_W'(x);
		ntsc_y = Y_W'(y);
		ntsc_pixel = d;
		lpf_flag = 1'b1;
		lpf_wr = 1'b1;
		lpf_x = X_W'(x);
		lpf_y = Y_W'(y);
		lpf_pixel_write = {lcg_state[3:0], lcg_state};
		next_cycle();
		ntsc_flag = 1'b0;
		check_done(1'b1, 1'b0, 1'b0, "clash first cycle");
		check_cmd(role_bank[0], word_addr(x, y, role_slot[0]), 1'b1, d, "clash capture");
		next_cycle();
		lpf_flag = 1'b0;
		check_done(1'b0, 1'b0, 1'b1, "clash second cycle");
		check_cmd(role_bank[1], word_addr(x, y, role_slot[1]), 1'b1, lpf_pixel_write,
			"clash filter");
	endtask

	// capture on one bank and display on the other in the same cycle
	task automatic capture_with_display(input int x, input int y, input logic [WORD_W-1:0] d);
		logic [ADDR_W-1:0] a;
		a = word_addr(x, y, role_slot[3]);
		ntsc_flag = 1'b1;
		ntsc_x = X_W'(x);
		ntsc_y = Y_W'(y);
		ntsc_pixel = d;
		start_display_read(x, y);
		next_cycle();
		ntsc_flag = 1'b0;
		vga_flag = 1'b0;
		check_done(1'b1, 1'b1, 1'b0, "capture with display");
		check_cmd(role_bank[0], word_addr(x, y, role_slot[0]), 1'b1, d, "parallel capture");
		check_cmd(role_bank[3], a, 1'b0, '0, "parallel display");
		repeat (3) next_cycle();
		last_vga = expect_word(role_bank[3], a);
		check_word(vga_pixel, last_vga, "parallel display data");
	endtask

	// display read then filter read on the next cycle on opposite banks
	task automatic back_to_back_reads(input int x, input int y);
		logic [ADDR_W-1:0] va;
		logic [ADDR_W-1:0] la;
		va = word_addr(x, y, role_slot[3]);
		la = word_addr(x, y, role_slot[1]);
		start_display_read(x, y);
		wait_for_done(1);
		vga_flag = 1'b0;
		start_filter_read(x, y);
		wait_for_done(2);
		lpf_flag = 1'b0;
		repeat (2) next_cycle();
		last_vga = expect_word(role_bank[3], va);
		check_word(vga_pixel, last_vga, "first of two reads");
		next_cycle();
		last_lpf = expect_word(role_bank[1], la);
		check_word(lpf_pixel_read, last_lpf, "second of two reads");
		check_word(vga_pixel, last_vga, "display hold after two reads");
	endtask

	task automatic idle_cycle();
		next_cycle();
		check_done(1'b0, 1'b0, 1'b0, "idle");
		checks++;
		if (mem0_wr !== 1'b0 || mem1_wr !== 1'b0)
			mismatch("idle cycle with a write on a bank");
		if (mem0_addr !== '0 || mem1_addr !== '0 || mem0_write !== '0 || mem1_write !== '0)
			mismatch("idle cycle with a nonzero bank address or write word");
		check_word(vga_pixel, last_vga, "display hold");
		check_word(lpf_pixel_read, last_lpf, "filter hold");
	endtask

	task automatic rotate_roles();
		int b [4];
		int s [4];
		b = role_bank;
		s = role_slot;
		frame_flag = 1'b1;
		next_cycle();
		frame_flag = 1'b0;
		// capture, process, next-display, display
		role_bank = '{b[1], b[3], b[0], b[2]};
		role_slot = '{s[1], s[3], s[0], s[2]};
	endtask

	initial begin
		int i;
		logic [99:0] r;
		frame_flag = 1'b0;
		ntsc_flag = 1'b0;
		vga_flag = 1'b0;
		lpf_flag = 1'b0;
		lpf_wr = 1'b0;
		ntsc_x = '0;
		ntsc_y = '0;
		hcount = '0;
		vcount = '0;
		lpf_x = '0;
		lpf_y = '0;
		ntsc_pixel = '0;
		lpf_pixel_write = '0;
		role_bank = '{0, 0, 1, 1};
		role_slot = '{0, 1, 0, 1};
		for (i = 0; i < MAX_ROWS; i++)
			rows[i] = {4'hf, 96'h0};
		$readmemh("testbench/frame_mem_patterns.hex", rows);
		while (num_rows < MAX_ROWS && rows[num_rows][99:96] != 4'hf)
			num_rows++;
		if (num_rows == 0) begin
			errors++;
			$display("no pattern rows were read from the pattern file");
		end
		@(negedge reset);
		check_done(1'b0, 1'b0, 1'b0, "after reset");
		checks++;
		if (mem0_wr !== 1'b0 || mem1_wr !== 1'b0 || mem0_addr !== '0 || mem1_addr !== '0)
			mismatch("bank command not idle after reset");
		for (i = 0; i < num_rows; i++) begin
			r = rows[i];
			case (r[99:96])
				4'h0: idle_cycle();
				4'h1: capture_write(int'(r[95:84]), int'(r[83:72]), r[71:36]);
				4'h2: filter_write(int'(r[95:84]), int'(r[83:72]));
				4'h3: filter_read(int'(r[95:84]), int'(r[83:72]));
				4'h4: display_read(int'(r[95:84]), int'(r[83:72]), r[35:0]);
				4'h5: rotate_roles();
				4'h6: capture_filter_clash(int'(r[95:84]), int'(r[83:72]), r[71:36]);
				4'h7: capture_with_display(int'(r[95:84]), int'(r[83:72]), r[71:36]);
				4'h8: back_to_back_reads(int'(r[95:84]), int'(r[83:72]));
				default: begin
					errors++;
					$display("unknown opcode %h in pattern row %0d", r[99:96], i);
				end
			endcase
		end
		$display("summary: %0d rows, %0d checks, %0d errors", num_rows, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// run length scales with the pattern count
	initial begin
		wait (num_rows > 0);
		#((num_rows * 20 + 200) * 10);
		$display("watchdog expired before the patterns finished");
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/frame_mem_patterns.hex */
// op(1) x(3) y(3) data(9) expected(9), op 0 idle 1 capture 2 filter write 3 filter read
// 4 display read 5 frame flag 6 clash 7 capture with display 8 two reads f end
100A003ABCDE1230000000000
0000000000000000000000000
6014005123456789000000000
3014005000000000000000000
7064010FEDCBA98000000000
4002000000000000000000000
0000000000000000000000000
0000000000000000000000000
2007007000000000000000000
3007007000000000000000000
8007007000000000000000000
5000000000000000000000000
101E002111222333000000000
5000000000000000000000000
400A003000000000ABCDE1230
4015005000000000123456789
203203C000000000000000000
303203C000000000000000000
800A003000000000000000000
8032003000000000000000000
0000000000000000000000000
F000000000000000000000000

/* filelist.f */
rtl/frame_mem_pkg.sv
rtl/buffer_rotation.sv
rtl/pixel_address.sv
rtl/bank_arbiter.sv
rtl/client_return.sv
rtl/frame_mem_top.sv
testbench/clock_gen.sv
testbench/sram_model.sv
testbench/tb_frame_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_frame_mem \
	-o sim_frame_mem
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_frame_mem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx '\*\* PASS \*\*'; then
	exit 0
fi
echo "pass message not found"
exit 1
